// File: list.f
src/eccm_pkg.sv
src/eccm_state_encoder.sv
src/policy_sequencer.sv
src/aie_beat_packer.sv
src/aie_beat_unpacker.sv
src/waveform_mapper.sv
src/cognitive_eccm_top.sv
dv/tb_cognitive_eccm.sv

// File: Bender.yml
package:
  name: cognitive_eccm

sources:
  - src/eccm_pkg.sv
  - src/eccm_state_encoder.sv
  - src/policy_sequencer.sv
  - src/aie_beat_packer.sv
  - src/aie_beat_unpacker.sv
  - src/waveform_mapper.sv
  - src/cognitive_eccm_top.sv
  - target: test
    files:
      - dv/tb_cognitive_eccm.sv

// File: dv/tb_cognitive_eccm.sv
`timescale 1ns/10ps

module tb_cognitive_eccm;
    import eccm_pkg::*;

    localparam int  freq_center  = 10000;
    localparam int  freq_range   = 500;
    localparam int  reset_cycles = 8;
    localparam real clk_period   = 20.0;
    localparam int  n_inferences = 35;  // 1 + 6 + 25 + 3 across the tests
    localparam real watchdog_ns  = 1.5 * (n_inferences * 64 + reset_cycles) * clk_period;

    logic            clk;
    logic            rst_n;
    jam_features_t   features;
    radar_feedback_t feedback;
    logic            features_valid;
    logic            features_ready;
    beat_t           aie_tx_data;
    logic            aie_tx_valid;
    logic            aie_tx_ready;
    beat_t           aie_rx_data;
    logic            aie_rx_valid;
    logic            aie_rx_ready;
    waveform_cmd_t   wave_cmd;
    logic            wave_update;
    eccm_stats_t     stats;

    int            errors;
    int            tests_run;
    int            tests_failed;
    int            update_count;  // wave_update pulses since reset
    int            stall_cycles;  // Features offered but refused
    int            busy_run;
    bit            model_held;    // Encoder snapshot model
    state_vec_t    exp_state_q[$];
    waveform_cmd_t exp_cmd_q[$];
    int            busy_q[$];     // Busy run lengths, one per inference
    int            code_param_ref[8] = '{13, 7, 16, 16, 16, 5, 7, 0};

    cognitive_eccm_top #(
        .freq_center_mhz (freq_center),
        .freq_range_mhz  (freq_range)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .features       (features),
        .feedback       (feedback),
        .features_valid (features_valid),
        .features_ready (features_ready),
        .aie_tx_data    (aie_tx_data),
        .aie_tx_valid   (aie_tx_valid),
        .aie_tx_ready   (aie_tx_ready),
        .aie_rx_data    (aie_rx_data),
        .aie_rx_valid   (aie_rx_valid),
        .aie_rx_ready   (aie_rx_ready),
        .wave_cmd       (wave_cmd),
        .wave_update    (wave_update),
        .stats          (stats)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Problem at %0t: %s", $time, msg);
        errors++;
    endtask

    // Lane table of the state encoder
    function automatic state_vec_t encode_state(input jam_features_t f,
                                                input radar_feedback_t fb);
        state_vec_t sv;
        sv    = '0;
        sv[0] = fb.freq;
        sv[1] = fb.prf;
        sv[2] = fb.bw;
        sv[3] = f.jnr[15:0];
        sv[4] = f.temporal_var[15:0];
        sv[5] = f.spectral_var[15:0];
        sv[6] = {14'd0, f.jammer_class};
        sv[9] = f.prf_stability[15:0];  // Lanes 7, 8 left zero
        return sv;
    endfunction

    function automatic beat_t pack_beat(input state_vec_t sv, input int idx);
        beat_t b;
        int    lane;
        b = '0;
        for (int k = 0; k < beat_w / sample_w; k++) begin
            lane = idx * (beat_w / sample_w) + k;
            if (lane < state_dim) b[k*sample_w +: sample_w] = sv[lane];  // Zero pad past lane 9
        end
        return b;
    endfunction

    // Mapping rules in plain integer arithmetic
    function automatic waveform_cmd_t map_action(input action_vec_t act);
        waveform_cmd_t c;
        int            a;
        int            off;
        c           = '0;
        a           = act[0];
        c.freq_word = 32'((freq_center + ((a * freq_range) >>> 8)) * 7158);
        a             = act[3];
        c.power_level = 8'(128 + (a >>> 1));
        off         = int'(act[4]) + 128;
        c.pol_state = 2'(off >> 6);
        if (c.pol_state == 2'd2) c.pol_phase_v = 8'd64;
        else if (c.pol_state == 2'd3) c.pol_phase_v = 8'd192;
        off            = int'(act[5]) + 128;
        c.phase_offset = 16'(off << 8);
        off           = int'(act[6]) + 128;
        c.code_select = 3'(off >> 5);
        c.code_param  = 8'(code_param_ref[c.code_select]);
        return c;
    endfunction

    task automatic check_cmd(input waveform_cmd_t got, input waveform_cmd_t exp);
        compare_value("wave_cmd.freq_word", got.freq_word, exp.freq_word);
        compare_value("wave_cmd.power_level", got.power_level, exp.power_level);
        compare_value("wave_cmd.pol_state", got.pol_state, exp.pol_state);
        compare_value("wave_cmd.pol_phase_h", got.pol_phase_h, exp.pol_phase_h);
        compare_value("wave_cmd.pol_phase_v", got.pol_phase_v, exp.pol_phase_v);
        compare_value("wave_cmd.phase_offset", got.phase_offset, exp.phase_offset);
        compare_value("wave_cmd.code_select", got.code_select, exp.code_select);
        compare_value("wave_cmd.code_param", got.code_param, exp.code_param);
    endtask

    function automatic jam_features_t random_features();
        jam_features_t f;
        f.jnr           = $urandom;
        f.temporal_var  = $urandom;
        f.spectral_var  = $urandom;
        f.prf_stability = $urandom;
        f.jammer_class  = 2'($urandom);
        return f;
    endfunction

    function automatic radar_feedback_t random_feedback();
        radar_feedback_t fb;
        fb.freq = 16'($urandom);
        fb.prf  = 16'($urandom);
        fb.bw   = 16'($urandom);
        return fb;
    endfunction

    function automatic action_vec_t random_action();
        action_vec_t act;
        for (int k = 0; k < action_dim; k++) begin
            act[k] = $signed(8'($urandom));  // Sign extended, -128..127
        end
        return act;
    endfunction

    // Monitor sampling at the falling edge, between drive points
    always @(negedge clk) begin
        if (!rst_n) begin
            model_held   = 1'b0;
            busy_run     = 0;
            update_count = 0;
            exp_state_q.delete();
            exp_cmd_q.delete();
            busy_q.delete();
        end else begin
            compare_value("features_ready", features_ready, !model_held);
            if (features_valid && !features_ready) stall_cycles++;
            if (features_valid && features_ready) begin
                exp_state_q.push_back(encode_state(features, feedback));
                model_held = 1'b1;
            end else if (model_held && !stats.busy) begin
                model_held = 1'b0;  // Taken while sequencer idles
            end
            if (stats.busy) begin
                busy_run++;
            end else if (busy_run > 0) begin
                busy_q.push_back(busy_run);
                busy_run = 0;
            end
            if (wave_update) begin
                update_count++;
                if (exp_cmd_q.size() == 0) report_problem("wave_update without an action beat");
                else check_cmd(wave_cmd, exp_cmd_q.pop_front());
                compare_value("stats.inference_count", stats.inference_count, update_count);
                if (busy_q.size() == 0) report_problem("wave_update before busy went low");
                else compare_value("stats.latency_cycles", stats.latency_cycles, busy_q.pop_front());
            end
        end
    end

    // Entry and exit at 2 ns after a rising edge
    task automatic send_features(input jam_features_t f, input radar_feedback_t fb);
        bit accepted;
        accepted       = 1'b0;
        features       = f;
        feedback       = fb;
        features_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = features_ready;  // Transfer on the coming edge
            @(posedge clk);
            #2;
        end
        features_valid = 1'b0;
    endtask

    // AI-engine kernel model, one round trip
    task automatic serve_aie_kernel(input action_vec_t act, input bit stall);
        state_vec_t exp_sv;
        beat_t      held_data;
        bit         stalled;
        bit         done;
        int         n;
        int         guard;
        exp_sv  = '0;
        stalled = 1'b0;
        n       = 0;
        guard   = 0;
        while (n < state_beats && guard < 64) begin
            aie_tx_ready = stall ? ($urandom_range(2) != 0) : 1'b1;
            @(negedge clk);
            if (stalled && !aie_tx_valid) report_problem("aie_tx_valid dropped during a stall");
            if (stalled && aie_tx_valid) compare_value("aie_tx_data (stalled)", aie_tx_data, held_data);
            stalled = 1'b0;
            if (aie_tx_valid && aie_tx_ready) begin
                if (n == 0) begin
                    if (exp_state_q.size() == 0) report_problem("TX beat with no features taken");
                    else exp_sv = exp_state_q.pop_front();
                end
                compare_value($sformatf("aie_tx_data beat %0d", n), aie_tx_data, pack_beat(exp_sv, n));
                n++;
            end else if (aie_tx_valid) begin
                stalled   = 1'b1;
                held_data = aie_tx_data;
            end
            guard++;
            @(posedge clk);
            #2;
        end
        aie_tx_ready = 1'b0;
        if (n < state_beats) begin
            report_problem("state vector never completed on the TX stream");
            return;
        end
        repeat ($urandom_range(3)) begin  // Kernel compute delay
            @(posedge clk);
            #2;
        end
        aie_rx_data  = {16'($urandom), act};  // Top lane is junk
        aie_rx_valid = 1'b1;
        done         = 1'b0;
        guard        = 0;
        while (!done && guard < 64) begin
            @(negedge clk);
            if (aie_rx_ready) begin
                done = 1'b1;
                exp_cmd_q.push_back(map_action(act));
            end
            guard++;
            @(posedge clk);
            #2;
        end
        aie_rx_valid = 1'b0;
        aie_rx_data  = '0;
        if (!done) report_problem("aie_rx_ready never rose for the action beat");
    endtask

    task automatic wait_for_updates(input int target);
        int guard;
        guard = 0;
        while (update_count < target && guard < 64) begin
            @(posedge clk);
            #2;
            guard++;
        end
        if (update_count < target) report_problem("wave_update did not arrive in time");
    endtask

    task automatic run_inference(input action_vec_t act, input bit stall);
        int target;
        target = update_count + 1;
        fork
            send_features(random_features(), random_feedback());
            serve_aie_kernel(act, stall);
        join
        wait_for_updates(target);
    endtask

    task automatic log_test_result(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-20s passed", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_reset_state();
        int            err0;
        waveform_cmd_t idle_cmd;
        err0                 = errors;
        idle_cmd             = '0;
        idle_cmd.power_level = 8'd128;
        @(negedge clk);
        compare_value("features_ready", features_ready, 1'b1);
        compare_value("aie_tx_valid", aie_tx_valid, 1'b0);
        compare_value("aie_rx_ready", aie_rx_ready, 1'b0);
        compare_value("wave_update", wave_update, 1'b0);
        compare_value("stats", stats, '0);
        check_cmd(wave_cmd, idle_cmd);
        @(posedge clk);
        #2;
        log_test_result("reset", err0);
    endtask

    task automatic run_single_inference();
        int err0;
        err0 = errors;
        run_inference(random_action(), 1'b0);
        repeat (6) begin  // No second pulse
            @(posedge clk);
            #2;
        end
        compare_value("wave_update count", update_count, 1);
        compare_value("stats.inference_count", stats.inference_count, 1);
        log_test_result("single_inference", err0);
    endtask

    task automatic stress_tx_backpressure();
        int err0;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            run_inference(random_action(), 1'b1);
        end
        compare_value("stats.inference_count", stats.inference_count, 7);
        log_test_result("tx_backpressure", err0);
    endtask

    task automatic sweep_mapping();
        int          err0;
        int          bounds[5] = '{-128, -65, 0, 63, 127};
        action_vec_t act;
        err0 = errors;
        foreach (bounds[i]) begin
            for (int k = 0; k < action_dim; k++) begin
                act[k] = sample_t'(bounds[i]);
            end
            run_inference(act, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            run_inference(random_action(), $urandom_range(1));
        end
        log_test_result("mapping_sweep", err0);
    endtask

    // Features queue up behind a running inference
    task automatic overlap_features();
        int err0;
        int target;
        int stalls0;
        err0    = errors;
        target  = update_count + 3;
        stalls0 = stall_cycles;
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    send_features(random_features(), random_feedback());
                end
            end
            begin
                for (int i = 0; i < 3; i++) begin
                    serve_aie_kernel(random_action(), 1'b1);
                end
            end
        join
        wait_for_updates(target);
        if (stall_cycles == stalls0) report_problem("features were never held off while busy");
        compare_value("stats.inference_count", stats.inference_count, target);
        log_test_result("busy_stall_stats", err0);
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0.0f ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(90));
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        stall_cycles   = 0;
        rst_n          = 1'b0;
        features       = '0;
        feedback       = '0;
        features_valid = 1'b0;
        aie_tx_ready   = 1'b0;
        aie_rx_data    = '0;
        aie_rx_valid   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_reset_state();
        run_single_inference();
        stress_tx_backpressure();
        sweep_mapping();
        overlap_features();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src/cognitive_eccm_top.sv
`timescale 1ns/10ps

module cognitive_eccm_top #(
    parameter int freq_center_mhz = 10000,
    parameter int freq_range_mhz  = 500
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  eccm_pkg::jam_features_t   features,
    input  eccm_pkg::radar_feedback_t feedback,
    input  logic                      features_valid,
    output logic                      features_ready,
    output eccm_pkg::beat_t           aie_tx_data,
    output logic                      aie_tx_valid,
    input  logic                      aie_tx_ready,
    input  eccm_pkg::beat_t           aie_rx_data,
    input  logic                      aie_rx_valid,
    output logic                      aie_rx_ready,
    output eccm_pkg::waveform_cmd_t   wave_cmd,
    output logic                      wave_update,
    output eccm_pkg::eccm_stats_t     stats
);
    import eccm_pkg::*;

    state_vec_t            state_vec;
    logic                  state_valid;
    logic                  state_take;
    logic                  state_load;
    logic [beat_idx_w-1:0] beat_idx;
    action_vec_t           action_vec;
    logic                  action_valid;

    eccm_state_encoder u_encoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .features       (features),
        .feedback       (feedback),
        .features_valid (features_valid),
        .features_ready (features_ready),
        .state_vec      (state_vec),
        .state_valid    (state_valid),
        .state_take     (state_take)
    );

    policy_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .state_valid  (state_valid),
        .state_take   (state_take),
        .state_load   (state_load),
        .beat_idx     (beat_idx),
        .aie_tx_valid (aie_tx_valid),
        .aie_tx_ready (aie_tx_ready),
        .aie_rx_valid (aie_rx_valid),
        .aie_rx_ready (aie_rx_ready),
        .action_valid (action_valid),
        .stats        (stats)
    );

    aie_beat_packer u_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_load  (state_load),
        .state_vec   (state_vec),
        .beat_idx    (beat_idx),
        .aie_tx_data (aie_tx_data)
    );

    // Capture on every accepted RX beat
    aie_beat_unpacker u_unpacker (
        .clk         (clk),
        .rst_n       (rst_n),
        .aie_rx_data (aie_rx_data),
        .capture     (aie_rx_ready & aie_rx_valid),
        .action_vec  (action_vec)
    );

    waveform_mapper #(
        .freq_center_mhz (freq_center_mhz),
        .freq_range_mhz  (freq_range_mhz)
    ) u_mapper (
        .clk          (clk),
        .rst_n        (rst_n),
        .action_vec   (action_vec),
        .action_valid (action_valid),
        .wave_cmd     (wave_cmd),
        .wave_update  (wave_update)
    );

endmodule

// File: src/waveform_mapper.sv
`timescale 1ns/10ps

module waveform_mapper #(
    parameter int freq_center_mhz = 10000,
    parameter int freq_range_mhz  = 500
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  eccm_pkg::action_vec_t   action_vec,
    input  logic                    action_valid,
    output eccm_pkg::waveform_cmd_t wave_cmd,
    output logic                    wave_update
);
    import eccm_pkg::*;

    localparam int frac_bits = 8;     // Q8.8
    localparam int ftw_scale = 7158;  // MHz to tuning word, approx

    action_vec_t         s1_vec;
    logic                s1_valid;
    waveform_cmd_t       cmd_d;
    logic signed [31:0]  freq_scaled;
    logic signed [31:0]  freq_mhz;
    logic [sample_w-1:0] power_delta;
    logic [sample_w-1:0] pol_sum;    // Lanes offset into 0..255
    logic [sample_w-1:0] phase_sum;
    logic [sample_w-1:0] code_sum;

    // Stage 1 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= action_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (action_valid) s1_vec <= action_vec;
    end

    always_comb begin
        freq_scaled = (32'($signed(s1_vec[0])) * 32'(freq_range_mhz)) >>> frac_bits;
        freq_mhz    = 32'(freq_center_mhz) + freq_scaled;
        power_delta = $signed(s1_vec[3]) >>> 1;  // Half step
        pol_sum     = s1_vec[4] + 16'd128;
        phase_sum   = s1_vec[5] + 16'd128;
        code_sum    = s1_vec[6] + 16'd128;

        cmd_d              = '0;
        cmd_d.freq_word    = freq_mhz * 32'(ftw_scale);
        cmd_d.power_level  = 8'd128 + power_delta[7:0];  // Centred on 128
        cmd_d.pol_state    = pol_sum[7:6];
        cmd_d.phase_offset = {phase_sum[7:0], 8'h00};
        cmd_d.code_select  = code_sum[7:5];

        case (cmd_d.pol_state)  // H phase always zero
            2'd2:    cmd_d.pol_phase_v = 8'd64;   // RHCP, +90 deg
            2'd3:    cmd_d.pol_phase_v = 8'd192;  // LHCP, -90 deg
            default: cmd_d.pol_phase_v = 8'd0;    // Linear H or V
        endcase

        case (cmd_d.code_select)
            3'd0:    cmd_d.code_param = 8'd13;  // Barker-13
            3'd1:    cmd_d.code_param = 8'd7;   // Barker-7
            3'd2,
            3'd3,
            3'd4:    cmd_d.code_param = 8'd16;  // Frank, P1, P2
            3'd5:    cmd_d.code_param = 8'd5;   // ZC root 5
            3'd6:    cmd_d.code_param = 8'd7;   // ZC root 7
            default: cmd_d.code_param = 8'd0;   // Dynamic code
        endcase
    end

    // Stage 2 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wave_cmd             <= '0;
            wave_cmd.power_level <= 8'd128;
            wave_update          <= 1'b0;
        end else begin
            wave_update <= s1_valid;
            if (s1_valid) wave_cmd <= cmd_d;
        end
    end

    // Fixed two cycle latency, both directions
    a_lat_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |-> ##2 wave_update);
    a_lat_back: assert property (@(posedge clk) disable iff (!rst_n)
        wave_update |-> $past(action_valid, 2));

endmodule

// File: src/aie_beat_unpacker.sv
`timescale 1ns/10ps

module aie_beat_unpacker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  eccm_pkg::beat_t       aie_rx_data,
    input  logic                  capture,
    output eccm_pkg::action_vec_t action_vec
);
    import eccm_pkg::*;

    localparam int act_w = action_dim * sample_w;  // 112 used bits

    action_vec_t action_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            action_q <= '0;
        end else if (capture) begin
            action_q <= aie_rx_data[act_w-1:0];  // Top lane dropped
        end
    end

    assign action_vec = action_q;

endmodule

// File: src/aie_beat_packer.sv
`timescale 1ns/10ps

module aie_beat_packer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            state_load,
    input  eccm_pkg::state_vec_t            state_vec,
    input  logic [eccm_pkg::beat_idx_w-1:0] beat_idx,
    output eccm_pkg::beat_t                 aie_tx_data
);
    import eccm_pkg::*;

    localparam int pad_w = state_beats * beat_w - state_dim * sample_w;

    beat_t [state_beats-1:0] beat_d;  // Zero padded on top of last beat
    beat_t [state_beats-1:0] beat_q;

    assign beat_d = {{pad_w{1'b0}}, state_vec};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (state_load) begin
            beat_q <= beat_d;
        end
    end

    assign aie_tx_data = beat_q[beat_idx];  // Stable while SEND stalls

    // Beats must hold for the whole round trip
    a_beats_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !state_load |=> $stable(beat_q));

endmodule

// File: src/policy_sequencer.sv
`timescale 1ns/10ps

module policy_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              state_valid,
    output logic                              state_take,
    output logic                              state_load,
    output logic [eccm_pkg::beat_idx_w-1:0]   beat_idx,
    output logic                              aie_tx_valid,
    input  logic                              aie_tx_ready,
    input  logic                              aie_rx_valid,
    output logic                              aie_rx_ready,
    output logic                              action_valid,
    output eccm_pkg::eccm_stats_t             stats
);
    import eccm_pkg::*;

    localparam int act_cnt_w = (action_beats > 1) ? $clog2(action_beats) : 1;

    typedef enum logic [1:0] {
        IDLE,
        SEND,    // State beats out to the kernel
        WAIT,    // Action beats back
        HANDOFF  // One cycle strobe to mapper
    } seq_state_t;

    seq_state_t             state_q;
    seq_state_t             state_d;
    logic [beat_idx_w-1:0]  beat_q;
    logic [act_cnt_w-1:0]   act_cnt;
    logic [15:0]            lat_cnt;   // Busy cycles so far
    logic [15:0]            lat_last;
    logic [31:0]            inf_cnt;
    logic                   tx_fire;
    logic                   rx_fire;
    logic                   last_beat;
    logic                   last_act;
    logic                   busy;

    assign tx_fire   = aie_tx_valid && aie_tx_ready;
    assign rx_fire   = aie_rx_valid && aie_rx_ready;
    assign last_beat = (beat_q == beat_idx_w'(state_beats - 1));
    assign last_act  = (act_cnt == act_cnt_w'(action_beats - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (state_valid) state_d = SEND;
            SEND:    if (tx_fire && last_beat) state_d = WAIT;
            WAIT:    if (rx_fire && last_act) state_d = HANDOFF;
            HANDOFF: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            beat_q   <= '0;
            act_cnt  <= '0;
            lat_cnt  <= '0;
            lat_last <= '0;
            inf_cnt  <= '0;
        end else begin
            state_q <= state_d;
            if (tx_fire) beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (rx_fire) act_cnt <= last_act ? '0 : act_cnt + 1'b1;
            lat_cnt <= busy ? lat_cnt + 16'd1 : '0;  // Zero on first SEND cycle
            if (state_q == HANDOFF) begin
                inf_cnt  <= inf_cnt + 32'd1;
                lat_last <= lat_cnt + 16'd1;  // Count the HANDOFF cycle too
            end
        end
    end

    assign state_take   = (state_q == IDLE) && state_valid;
    assign state_load   = state_take;  // Packer captures on the take
    assign beat_idx     = beat_q;
    assign aie_tx_valid = (state_q == SEND);
    assign aie_rx_ready = (state_q == WAIT);
    assign action_valid = (state_q == HANDOFF);
    assign busy         = (state_q != IDLE);

    always_comb begin
        stats.inference_count = inf_cnt;
        stats.latency_cycles  = lat_last;
        stats.busy            = busy;
    end

    // Beat select never runs past the packed vector
    a_beat_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == SEND) |-> (beat_idx < state_beats));

    // Mapper sees isolated pulses only
    a_action_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid);

endmodule

// File: src/eccm_state_encoder.sv
`timescale 1ns/10ps

module eccm_state_encoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  eccm_pkg::jam_features_t   features,
    input  eccm_pkg::radar_feedback_t feedback,
    input  logic                      features_valid,
    output logic                      features_ready,
    output eccm_pkg::state_vec_t      state_vec,
    output logic                      state_valid,
    input  logic                      state_take
);
    import eccm_pkg::*;

    state_vec_t state_d;  // Lanes built from current inputs
    state_vec_t state_q;  // Held snapshot
    logic       held_q;

    always_comb begin
        state_d    = '0;  // Lanes 7 and 8 stay zero
        state_d[0] = feedback.freq;
        state_d[1] = feedback.prf;
        state_d[2] = feedback.bw;
        state_d[3] = features.jnr[15:0];           // Low halves only
        state_d[4] = features.temporal_var[15:0];
        state_d[5] = features.spectral_var[15:0];
        state_d[6] = sample_w'(features.jammer_class);
        state_d[9] = features.prf_stability[15:0];
    end

    assign features_ready = !held_q;  // Stall while a snapshot waits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else if (features_valid && features_ready) begin
            held_q <= 1'b1;
        end else if (state_take) begin
            held_q <= 1'b0;  // Sequencer took it
        end
    end

    always_ff @(posedge clk) begin
        if (features_valid && features_ready) begin
            state_q <= state_d;
        end
    end

    assign state_vec   = state_q;
    assign state_valid = held_q;

endmodule

// File: src/eccm_pkg.sv
package eccm_pkg;

    // Vector geometry
    parameter int sample_w   = 16;  // Q8.8 lane
    parameter int state_dim  = 10;
    parameter int action_dim = 7;
    parameter int beat_w     = 128; // AI-engine stream width

    // Beats needed per vector, rounded up
    parameter int state_beats  = (state_dim * sample_w + beat_w - 1) / beat_w;
    parameter int action_beats = (action_dim * sample_w + beat_w - 1) / beat_w;

    // Beat index width, at least one bit
    parameter int beat_idx_w = (state_beats > 1) ? $clog2(state_beats) : 1;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic [beat_w-1:0]          beat_t;

    // Lane i sits at bits sample_w*i
    typedef sample_t [state_dim-1:0]  state_vec_t;
    typedef sample_t [action_dim-1:0] action_vec_t;

    // Jammer classifier output
    typedef struct packed {
        logic [31:0] jnr;
        logic [31:0] temporal_var;
        logic [31:0] spectral_var;
        logic [31:0] prf_stability;
        logic [1:0]  jammer_class;
    } jam_features_t;

    // Current radar settings
    typedef struct packed {
        logic [15:0] freq;
        logic [15:0] prf;
        logic [15:0] bw;
    } radar_feedback_t;

    // Waveform generator command word
    typedef struct packed {
        logic [31:0] freq_word;    // NCO tuning word
        logic [7:0]  power_level;  // PA DAC code
        logic [1:0]  pol_state;    // H, V, RHCP, LHCP
        logic [7:0]  pol_phase_h;
        logic [7:0]  pol_phase_v;
        logic [15:0] phase_offset; // Full circle over 16 bits
        logic [2:0]  code_select;
        logic [7:0]  code_param;
    } waveform_cmd_t;

    typedef struct packed {
        logic [31:0] inference_count;
        logic [15:0] latency_cycles;
        logic        busy;
    } eccm_stats_t;

endpackage
